// File: include/pkt_buf_config.svh
`ifndef PKT_BUF_CONFIG_SVH
`define PKT_BUF_CONFIG_SVH

// Sizing of the packet buffer

// Width of one data word in bits
`define PKT_BUF_WIDTH		32

// Number of words in the single-port memory
`define PKT_BUF_DEPTH		64

// log2 of the depth
// Pointers and counts carry one bit more than this
`define PKT_BUF_ADDR_BITS	6

`endif

// File: verilog/pkt_buf_pkg.sv
`default_nettype none

`include "pkt_buf_config.svh"

package pkt_buf_pkg;

	// One stored word, payload is opaque to the buffer
	typedef logic [`PKT_BUF_WIDTH-1:0] word_t;

	// Memory address, wraps at the depth
	typedef logic [`PKT_BUF_ADDR_BITS-1:0] addr_t;

	// Pointer or word count
	// Extra MSB tells full from empty and lets a count reach the full depth
	typedef logic [`PKT_BUF_ADDR_BITS:0] ptr_t;

endpackage

`default_nettype wire

// File: verilog/pkt_sram.sv
`timescale 1ns/100ps
`default_nettype none

`include "pkt_buf_config.svh"

// Single-port storage array shared by writer and reader
module pkt_sram #(
	parameter type data_t = logic
) (
	input wire rd_clk,
	input wire en,						// Port enable, one access per cycle
	input wire we,						// High for write, low for read
	input wire pkt_buf_pkg::addr_t addr,
	input wire data_t din,				// Write word
	output data_t dout					// Read word, one cycle after the access
);

	////////////////////
	// Storage

	data_t mem [`PKT_BUF_DEPTH];		// Contents undefined after reset

	////////////////////
	// Access port

	always_ff @(posedge rd_clk) begin
		if (en) begin
			if (we) begin
				mem[addr] <= din;		// Stored at the end of the write cycle
			end else begin
				dout <= mem[addr];		// Held until the next read
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/pkt_mem_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

// Shares the single memory port between write and read controllers
// Writes win every cycle they strobe, a read waits in a one-deep holding slot
module pkt_mem_arbiter #(
	parameter type data_t = logic
) (
	input wire rd_clk,
	input wire rd_reset,

	// Writer
	input wire mem_wr_en,						// Write strobe, always granted
	input wire pkt_buf_pkg::addr_t mem_wr_addr,
	input wire data_t wr_data,

	// Reader
	input wire mem_rd_req,						// Read request pulse
	input wire pkt_buf_pkg::addr_t mem_rd_addr,
	output data_t rd_data,
	output logic rd_valid,						// Pulses one cycle after the grant

	// Memory port
	output logic sram_en,
	output logic sram_we,
	output pkt_buf_pkg::addr_t sram_addr,
	output data_t sram_din,
	input wire data_t sram_dout
);

	logic rd_pending;							// A read is waiting for a free cycle
	pkt_buf_pkg::addr_t rd_pend_addr;			// Address of the waiting read
	logic rd_want;
	logic rd_grant;
	pkt_buf_pkg::addr_t rd_addr;

	////////////////////
	// Grant logic

	assign rd_want  = rd_pending | mem_rd_req;	// Held read or a fresh one
	assign rd_addr  = rd_pending ? rd_pend_addr : mem_rd_addr;
	assign rd_grant = rd_want & ~mem_wr_en;		// Only in cycles with no write

	// Memory port mux
	assign sram_en   = mem_wr_en | rd_grant;
	assign sram_we   = mem_wr_en;
	assign sram_addr = mem_wr_en ? mem_wr_addr : rd_addr;
	assign sram_din  = wr_data;

	// Memory output is already registered
	assign rd_data = sram_dout;

	////////////////////
	// Pending read and valid

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			rd_pending <= 1'b0;
			rd_valid   <= 1'b0;
		end else begin
			rd_pending <= rd_want & mem_wr_en;	// Stays pending while writes keep coming
			rd_valid   <= rd_grant;				// Lines up with sram_dout
		end
	end

	// Capture address in the request cycle, later pops cannot move it
	always_ff @(posedge rd_clk) begin
		if (mem_rd_req) begin
			rd_pend_addr <= mem_rd_addr;
		end
	end

	////////////////////
	// Checks

	// Returned word came from a cycle where the writer did not hold the port
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		rd_valid |-> $past(sram_en && !sram_we));

	// Only one read in the holding slot at a time
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		mem_rd_req |-> !rd_pending);

endmodule

`default_nettype wire

// File: verilog/pkt_write_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "pkt_buf_config.svh"

// Write side pointers
// Working pointer moves per word, committed tail moves only on commit
module pkt_write_ctrl (
	input wire rd_clk,
	input wire rd_reset,
	input wire wr_en,						// Push one word
	input wire wr_commit,					// Make everything written so far readable
	input wire wr_rollback,					// Drop everything since the last commit
	input wire pkt_buf_pkg::ptr_t head,		// Read pointer from the read side
	output pkt_buf_pkg::ptr_t tail,			// Committed write pointer
	output pkt_buf_pkg::ptr_t wr_size,		// Free space in words
	output logic mem_wr_en,
	output pkt_buf_pkg::addr_t mem_wr_addr
);

	localparam pkt_buf_pkg::ptr_t buf_depth = `PKT_BUF_DEPTH;

	pkt_buf_pkg::ptr_t wr_ptr;				// Working write pointer
	pkt_buf_pkg::ptr_t wr_ptr_next;
	logic wr_full;

	////////////////////
	// Space and accept

	// Extra pointer bit keeps this correct across the wrap
	assign wr_size = buf_depth + head - wr_ptr;
	assign wr_full = (wr_size == '0);

	// Full drops the word, rollback discards a write in the same cycle
	assign mem_wr_en   = wr_en & ~wr_full & ~wr_rollback;
	assign mem_wr_addr = wr_ptr[`PKT_BUF_ADDR_BITS-1:0];
	assign wr_ptr_next = wr_ptr + pkt_buf_pkg::ptr_t'(mem_wr_en);

	////////////////////
	// Pointer update

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			wr_ptr <= '0;
			tail   <= '0;
		end else begin
			if (wr_rollback) begin
				wr_ptr <= tail;				// Back to the last committed point
			end else begin
				wr_ptr <= wr_ptr_next;
			end
			if (wr_commit) begin
				tail <= wr_ptr_next;		// Includes a write in the commit cycle
			end
		end
	end

	// Commit and rollback are exclusive requests
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		!(wr_commit && wr_rollback));

endmodule

`default_nettype wire

// File: verilog/pkt_read_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

// Read side pointer
// Random access inside the committed region, pops move the head
module pkt_read_ctrl (
	input wire rd_clk,
	input wire rd_reset,

	// Random-access read
	input wire rd_en,							// Read one word
	input wire pkt_buf_pkg::addr_t rd_offset,	// Offset from the packet start

	// Pops
	input wire rd_pop_single,					// Drop one word
	input wire rd_pop_packet,					// Drop a whole packet
	input wire pkt_buf_pkg::ptr_t rd_packet_size,

	// Pointer exchange with the write side
	input wire pkt_buf_pkg::ptr_t tail,			// Committed write pointer
	output pkt_buf_pkg::ptr_t head,				// Read pointer
	output pkt_buf_pkg::ptr_t rd_size,			// Committed words held

	// Memory request toward the arbiter
	output logic mem_rd_req,
	output pkt_buf_pkg::addr_t mem_rd_addr
);

	pkt_buf_pkg::addr_t head_addr;				// Head without the wrap bit
	logic rd_empty;

	////////////////////
	// Occupancy

	// Only committed words count, uncommitted data stays invisible
	assign rd_size  = tail - head;
	assign rd_empty = (rd_size == '0);

	////////////////////
	// Read address

	assign head_addr = head[$bits(pkt_buf_pkg::addr_t)-1:0];

	// Wraps naturally at the depth
	assign mem_rd_addr = head_addr + rd_offset;
	assign mem_rd_req  = rd_en;					// Arbiter latches the address

	////////////////////
	// Pops

	always_ff @(posedge rd_clk) begin
		if (rd_reset) begin
			head <= '0;
		end else if (rd_pop_single) begin
			if (!rd_empty) begin
				head <= head + 1'b1;			// Ignored when nothing is held
			end
		end else if (rd_pop_packet) begin
			head <= head + rd_packet_size;		// Whole packet in one step
		end
	end

	////////////////////
	// Checks

	// One pop kind per cycle
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		!(rd_pop_single && rd_pop_packet));

	// Packet pop stays inside the committed region
	assert property (@(posedge rd_clk) disable iff (rd_reset)
		rd_pop_packet |-> (rd_packet_size <= rd_size));

endmodule

`default_nettype wire

// File: verilog/pkt_buffer_top.sv
`timescale 1ns/100ps
`default_nettype none

// Packet buffer with commit/rollback on the write side
// Both sides share one single-port memory through the arbiter
module pkt_buffer_top (
	input wire rd_clk,
	input wire rd_reset,

	// Write side
	input wire wr_en,
	input wire pkt_buf_pkg::word_t wr_data,
	input wire wr_commit,
	input wire wr_rollback,
	output pkt_buf_pkg::ptr_t wr_size,			// Free space

	// Read side
	input wire rd_en,
	input wire pkt_buf_pkg::addr_t rd_offset,
	input wire rd_pop_single,
	input wire rd_pop_packet,
	input wire pkt_buf_pkg::ptr_t rd_packet_size,
	output pkt_buf_pkg::word_t rd_data,
	output logic rd_valid,						// Marks rd_data
	output pkt_buf_pkg::ptr_t rd_size			// Committed words held
);

	////////////////////
	// Internal wiring

	pkt_buf_pkg::ptr_t tail;					// Committed write pointer
	pkt_buf_pkg::ptr_t head;					// Read pointer
	logic mem_wr_en;
	pkt_buf_pkg::addr_t mem_wr_addr;
	logic mem_rd_req;
	pkt_buf_pkg::addr_t mem_rd_addr;

	// Memory port
	logic sram_en;
	logic sram_we;
	pkt_buf_pkg::addr_t sram_addr;
	pkt_buf_pkg::word_t sram_din;
	pkt_buf_pkg::word_t sram_dout;

	////////////////////
	// Write and read control

	pkt_write_ctrl u_pkt_write_ctrl (
		.rd_clk      (rd_clk),
		.rd_reset    (rd_reset),
		.wr_en       (wr_en),
		.wr_commit   (wr_commit),
		.wr_rollback (wr_rollback),
		.head        (head),
		.tail        (tail),
		.wr_size     (wr_size),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr)
	);

	pkt_read_ctrl u_pkt_read_ctrl (
		.rd_clk         (rd_clk),
		.rd_reset       (rd_reset),
		.rd_en          (rd_en),
		.rd_offset      (rd_offset),
		.rd_pop_single  (rd_pop_single),
		.rd_pop_packet  (rd_pop_packet),
		.rd_packet_size (rd_packet_size),
		.tail           (tail),
		.head           (head),
		.rd_size        (rd_size),
		.mem_rd_req     (mem_rd_req),
		.mem_rd_addr    (mem_rd_addr)
	);

	////////////////////
	// Shared memory

	pkt_mem_arbiter #(
		.data_t (pkt_buf_pkg::word_t)
	) u_pkt_mem_arbiter (
		.rd_clk      (rd_clk),
		.rd_reset    (rd_reset),
		.mem_wr_en   (mem_wr_en),
		.mem_wr_addr (mem_wr_addr),
		.wr_data     (wr_data),
		.mem_rd_req  (mem_rd_req),
		.mem_rd_addr (mem_rd_addr),
		.rd_data     (rd_data),
		.rd_valid    (rd_valid),
		.sram_en     (sram_en),
		.sram_we     (sram_we),
		.sram_addr   (sram_addr),
		.sram_din    (sram_din),
		.sram_dout   (sram_dout)
	);

	pkt_sram #(
		.data_t (pkt_buf_pkg::word_t)
	) u_pkt_sram (
		.rd_clk (rd_clk),
		.en     (sram_en),
		.we     (sram_we),
		.addr   (sram_addr),
		.din    (sram_din),
		.dout   (sram_dout)
	);

endmodule

`default_nettype wire

// File: dv/pkt_buffer_checker.sv
`timescale 1ns/100ps
`default_nettype none

`include "pkt_buf_config.svh"

// Reference model of the packet buffer, watches the DUT ports only
module pkt_buffer_checker (
	input wire rd_clk,
	input wire rd_reset,
	input wire wr_en,
	input wire pkt_buf_pkg::word_t wr_data,
	input wire wr_commit,
	input wire wr_rollback,
	input wire pkt_buf_pkg::ptr_t wr_size,
	input wire rd_en,
	input wire pkt_buf_pkg::addr_t rd_offset,
	input wire rd_pop_single,
	input wire rd_pop_packet,
	input wire pkt_buf_pkg::ptr_t rd_packet_size,
	input wire pkt_buf_pkg::word_t rd_data,
	input wire rd_valid,
	input wire pkt_buf_pkg::ptr_t rd_size
);

	localparam int depth = `PKT_BUF_DEPTH;

	pkt_buf_pkg::word_t committed[$];		// Readable words, head first
	pkt_buf_pkg::word_t uncommitted[$];		// Written since the last commit
	pkt_buf_pkg::word_t expect_rd[$];		// Words owed by outstanding reads

	int error_count = 0;
	string test_name = "none";				// Set by the testbench per test

	task automatic flag_mismatch(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("MISMATCH test %s %s: expected %0h, actual %0h",
			test_name, what, expected, actual);
		error_count++;
	endtask

	////////////////////
	// Model update and compare

	// Sampled at the edge, so inputs and outputs both show the cycle that just ended
	always @(posedge rd_clk) begin
		int held;
		pkt_buf_pkg::word_t exp_word;
		if (rd_reset) begin
			committed.delete();
			uncommitted.delete();
			expect_rd.delete();				// A pending read dies with the reset
		end else begin
			held = committed.size() + uncommitted.size();

			// Sizes reflect state before this edge
			if (rd_size !== pkt_buf_pkg::ptr_t'(committed.size()))
				flag_mismatch("rd_size", committed.size(), rd_size);
			if (wr_size !== pkt_buf_pkg::ptr_t'(depth - held))
				flag_mismatch("wr_size", depth - held, wr_size);

			// Returned word, checked before a new request is queued
			if (rd_valid) begin
				if (expect_rd.size() == 0) begin
					$display("ERROR test %s: rd_valid pulsed with no read outstanding",
						test_name);
					error_count++;
				end else begin
					exp_word = expect_rd.pop_front();
					if (rd_data !== exp_word)
						flag_mismatch("rd_data", exp_word, rd_data);
				end
			end

			// Address taken from the head before any pop in this cycle
			if (rd_en) begin
				if (rd_offset < committed.size()) begin
					expect_rd.push_back(committed[rd_offset]);
				end else begin
					$display("ERROR test %s: read at offset %0d beyond %0d committed words",
						test_name, rd_offset, committed.size());
					error_count++;
					expect_rd.push_back('x);
				end
			end

			// Pops see the committed count from before a same-cycle commit
			if (rd_pop_single) begin
				if (committed.size() > 0)
					committed.delete(0);	// Empty buffer ignores the pop
			end else if (rd_pop_packet) begin
				for (int i = 0; i < rd_packet_size && committed.size() > 0; i++)
					committed.delete(0);
			end

			// Rollback wins over a write in the same cycle
			if (wr_rollback)
				uncommitted.delete();
			else if (wr_en && held < depth)
				uncommitted.push_back(wr_data);	// Full drops the word

			if (wr_commit) begin
				while (uncommitted.size() > 0)
					committed.push_back(uncommitted.pop_front());
			end
		end
	end

endmodule

`default_nettype wire

// File: dv/pkt_buffer_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pkt_buf_config.svh"

module pkt_buffer_tb;

	localparam int depth = `PKT_BUF_DEPTH;
	localparam int rd_timeout = 40;			// Cycles allowed for one read

	logic rd_clk;
	logic rd_reset;
	logic wr_en;
	pkt_buf_pkg::word_t wr_data;
	logic wr_commit;
	logic wr_rollback;
	pkt_buf_pkg::ptr_t wr_size;
	logic rd_en;
	pkt_buf_pkg::addr_t rd_offset;
	logic rd_pop_single;
	logic rd_pop_packet;
	pkt_buf_pkg::ptr_t rd_packet_size;
	pkt_buf_pkg::word_t rd_data;
	logic rd_valid;
	pkt_buf_pkg::ptr_t rd_size;

	integer seed;
	int tests_run;
	int tests_failed;
	int errors_before;
	string current_test;

	pkt_buffer_top u_pkt_buffer_top (.*);
	pkt_buffer_checker u_pkt_buffer_checker (.*);

	initial rd_clk = 1'b0;
	always #20 rd_clk = ~rd_clk;			// 40 ns period

	////////////////////
	// Stimulus helpers

	function automatic int rand_between(input int lo, input int hi);
		return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
	endfunction

	// Every step starts from all strobes low
	task automatic clear_strobes();
		wr_en <= 1'b0;
		wr_commit <= 1'b0;
		wr_rollback <= 1'b0;
		rd_en <= 1'b0;
		rd_pop_single <= 1'b0;
		rd_pop_packet <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge rd_clk);
			clear_strobes();
		end
	endtask

	task automatic write_words(input int len, input bit commit_last);
		for (int i = 0; i < len; i++) begin
			@(posedge rd_clk);
			clear_strobes();
			wr_en <= 1'b1;
			wr_data <= $random(seed);
			wr_commit <= commit_last && (i == len - 1);
		end
	endtask

	task automatic rollback_step(input bit with_write);
		@(posedge rd_clk);
		clear_strobes();
		wr_rollback <= 1'b1;
		if (with_write) begin
			wr_en <= 1'b1;					// Discarded by the rollback
			wr_data <= $random(seed);
		end
	endtask

	task automatic pop_one();
		@(posedge rd_clk);
		clear_strobes();
		rd_pop_single <= 1'b1;
	endtask

	task automatic pop_packet_step(input int len);
		@(posedge rd_clk);
		clear_strobes();
		rd_pop_packet <= 1'b1;
		rd_packet_size <= pkt_buf_pkg::ptr_t'(len);
	endtask

	// Read one word while writes in the first cycles stretch the latency
	task automatic read_word(input int offset, input int writes);
		int left;
		int cycles;
		bit got;
		left = writes;
		cycles = 0;
		got = 1'b0;
		@(posedge rd_clk);
		clear_strobes();
		rd_en <= 1'b1;
		rd_offset <= pkt_buf_pkg::addr_t'(offset);
		while (!got && cycles < rd_timeout) begin
			if (left > 0) begin
				wr_en <= 1'b1;
				wr_data <= $random(seed);
				left--;
			end
			@(posedge rd_clk);
			cycles++;
			got = rd_valid;
			clear_strobes();
		end
		if (!got) begin
			$display("Timeout: no rd_valid within %0d cycles of a read in test %s",
				rd_timeout, current_test);
			$display("Some tests failed");
			$finish;
		end
	endtask

	task automatic start_test(input string name);
		current_test = name;
		u_pkt_buffer_checker.test_name = name;
		errors_before = u_pkt_buffer_checker.error_count;
	endtask

	task automatic end_test();
		int errs;
		idle_cycles(3);						// Let the last read and sizes settle
		@(negedge rd_clk);					// Checker is done with the last edge
		errs = u_pkt_buffer_checker.error_count - errors_before;
		tests_run++;
		if (errs == 0) begin
			$display("Test %s: ok", current_test);
		end else begin
			tests_failed++;
			$display("Test %s: FAILED with %0d errors", current_test, errs);
		end
	endtask

	////////////////////
	// Test sequence

	initial begin
		int len;
		int len0;
		int len1;
		int total;
		seed = 32'hd6fab384;
		tests_run = 0;
		tests_failed = 0;
		rd_reset = 1'b1;
		wr_en = 1'b0;
		wr_data = '0;
		wr_commit = 1'b0;
		wr_rollback = 1'b0;
		rd_en = 1'b0;
		rd_offset = '0;
		rd_pop_single = 1'b0;
		rd_pop_packet = 1'b0;
		rd_packet_size = '0;
		repeat (10) @(posedge rd_clk);
		rd_reset <= 1'b0;
		idle_cycles(2);

		// Packets come back in write order with one pop per word
		start_test("commit_pop_single");
		total = 0;
		for (int p = 0; p < 3; p++) begin
			len = rand_between(1, 8);
			write_words(len, 1'b1);
			total += len;
		end
		idle_cycles(1);
		for (int i = 0; i < total; i++) begin
			read_word(0, 0);
			pop_one();
		end
		end_test();

		// Rolled back words never show up
		start_test("rollback");
		len = rand_between(2, 6);
		write_words(len, 1'b1);
		write_words(rand_between(1, 8), 1'b0);
		rollback_step(1'b0);
		write_words(rand_between(1, 4), 1'b0);
		rollback_step(1'b1);
		idle_cycles(2);
		for (int i = 0; i < len; i++) begin
			read_word(0, 0);
			pop_one();
		end
		end_test();

		// Random offsets inside the head packet while writes vary the latency
		start_test("offset_reads");
		len0 = rand_between(4, 12);
		write_words(len0, 1'b1);
		len1 = rand_between(4, 12);
		write_words(len1, 1'b1);
		repeat (8) read_word(rand_between(0, len0 - 1), rand_between(0, 3));
		rollback_step(1'b0);				// Drops the interleaved writes
		pop_packet_step(len0);
		repeat (6) read_word(rand_between(0, len1 - 1), rand_between(0, 3));
		rollback_step(1'b0);
		pop_packet_step(len1);
		end_test();

		// Writes past full are dropped
		start_test("fill_drop");
		write_words(depth + 4, 1'b1);
		idle_cycles(2);
		for (int i = 0; i < depth; i++) begin
			read_word(0, 0);
			pop_one();
		end
		end_test();

		// Empty pops and then a reset that lands while writes hold off a read
		start_test("empty_and_reset");
		pop_one();
		pop_one();
		idle_cycles(2);
		write_words(4, 1'b1);
		write_words(3, 1'b0);
		@(posedge rd_clk);
		clear_strobes();
		rd_en <= 1'b1;
		rd_offset <= '0;
		wr_en <= 1'b1;
		wr_data <= $random(seed);
		repeat (3) begin
			@(posedge rd_clk);
			clear_strobes();
			wr_en <= 1'b1;
			wr_data <= $random(seed);
		end
		@(posedge rd_clk);
		clear_strobes();
		wr_en <= 1'b1;						// Read still waiting when reset hits
		wr_data <= $random(seed);
		rd_reset <= 1'b1;
		repeat (2) @(posedge rd_clk);
		clear_strobes();
		rd_reset <= 1'b0;
		idle_cycles(8);						// Checker flags any stray rd_valid
		end_test();

		$display("Tests run %0d, failed %0d, errors %0d",
			tests_run, tests_failed, u_pkt_buffer_checker.error_count);
		if (tests_failed == 0 && u_pkt_buffer_checker.error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
verilog/pkt_buf_pkg.sv
verilog/pkt_sram.sv
verilog/pkt_mem_arbiter.sv
verilog/pkt_write_ctrl.sv
verilog/pkt_read_ctrl.sv
verilog/pkt_buffer_top.sv
dv/pkt_buffer_checker.sv
dv/pkt_buffer_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the packet buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f --top-module pkt_buffer_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vpkt_buffer_tb > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Some tests failed" "$log_file"; then
	exit 1
fi
exit 0
